// File: project.f
cpu_pkg.sv
bus_req_issue.sv
bus_req_fifo.sv
bus_master.sv
bus_cpu.sv
tb_bus_slave.sv
tb_bus_cpu.sv

// File: Bender.yml
package:
  name: bus_cpu

sources:
  # RTL, package first
  - files:
      - cpu_pkg.sv
      - bus_req_issue.sv
      - bus_req_fifo.sv
      - bus_master.sv
      - bus_cpu.sv

  # Testbench
  - target: test
    files:
      - tb_bus_slave.sv
      - tb_bus_cpu.sv

// File: tb_bus_cpu.sv
// Testbench for the CPU system bus request path
// Drives the command port, predicts every response from the bus rules
// and checks responses, strobes and flow control with assertions

`timescale 1ns/1ps
`default_nettype none

module tb_bus_cpu;

	localparam int WAIT_LIMIT = 4 * cpu_pkg::ALARM_DLY_TICKS;
	localparam int MAX_CMDS = 256;

	logic                         __clk;
	logic                         rst_n;
	logic                         cmd_valid;
	logic                         cmd_ready;
	logic                         cmd_io;
	logic                         cmd_write;
	cpu_pkg::bus_addr_u           cmd_addr;
	logic [0:cpu_pkg::WORD_W-1]   cmd_data;
	logic                         dr;
	logic                         dw;
	logic                         din;
	logic [0:cpu_pkg::WORD_W-1]   dad;
	logic [0:cpu_pkg::WORD_W-1]   ddt;
	logic                         rok;
	logic                         ren;
	logic                         rpe;
	logic [0:cpu_pkg::WORD_W-1]   rdt;
	logic                         rsp_valid;
	logic [0:cpu_pkg::STATUS_W-1] rsp_status;
	logic [0:cpu_pkg::WORD_W-1]   rsp_data;
	logic                         awaria;
	logic                         slow;

	// Scoreboard, indexed by command order
	logic [0:cpu_pkg::STATUS_W-1] exp_status [MAX_CMDS];
	logic [0:cpu_pkg::WORD_W-1]   exp_data [MAX_CMDS];
	logic [0:cpu_pkg::WORD_W-1]   shadow [logic [0:cpu_pkg::WORD_W-1]];
	logic [0:cpu_pkg::STATUS_W-1] head_status;
	logic [0:cpu_pkg::WORD_W-1]   head_data;
	int                           issue_cnt;
	int                           acc_cnt;
	int                           rsp_cnt;
	logic                         saw_stall;
	logic                         alarm_issued;
	logic                         no_dw_watch;
	logic                         no_din_watch;
	string                        test_name;

	bus_cpu i_bus_cpu (
		.__clk(__clk),
		.rst_n(rst_n),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.cmd_io(cmd_io),
		.cmd_write(cmd_write),
		.cmd_addr(cmd_addr),
		.cmd_data(cmd_data),
		.dr(dr),
		.dw(dw),
		.din(din),
		.dad(dad),
		.ddt(ddt),
		.rok(rok),
		.ren(ren),
		.rpe(rpe),
		.rdt(rdt),
		.rsp_valid(rsp_valid),
		.rsp_status(rsp_status),
		.rsp_data(rsp_data),
		.awaria(awaria)
	);

	tb_bus_slave i_tb_bus_slave (
		.__clk(__clk),
		.rst_n(rst_n),
		.slow(slow),
		.dr(dr),
		.dw(dw),
		.din(din),
		.dad(dad),
		.ddt(ddt),
		.rok(rok),
		.ren(ren),
		.rpe(rpe),
		.rdt(rdt)
	);

	initial begin
		__clk = 1'b0;
		forever #2 __clk = ~__clk;
	end

	assign head_status = exp_status[rsp_cnt];
	assign head_data = exp_data[rsp_cnt];

	// Accepted and answered command counts
	always @(posedge __clk) begin
		if (!rst_n) begin
			acc_cnt <= 0;
			rsp_cnt <= 0;
			saw_stall <= 1'b0;
		end else begin
			if (cmd_valid && cmd_ready)
				acc_cnt <= acc_cnt + 1;
			if (rsp_valid)
				rsp_cnt <= rsp_cnt + 1;
			if ((acc_cnt - rsp_cnt == cpu_pkg::FIFO_DEPTH + 1) && !cmd_ready)
				saw_stall <= 1'b1;
		end
	end

	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	// -----------------------------------------------------------------
	// Checks
	// -----------------------------------------------------------------

	a_rsp_accepted: assert property (@(posedge __clk) disable iff (!rst_n)
		rsp_valid |-> (rsp_cnt < acc_cnt))
		else fail_stop("A response arrived with no accepted command outstanding");

	a_rsp_status: assert property (@(posedge __clk) disable iff (!rst_n)
		rsp_valid |-> (rsp_status == head_status))
		else fail_stop($sformatf("[FAIL] %s rsp_status: expected %0d actual %0d",
			test_name, $sampled(head_status), $sampled(rsp_status)));

	a_rsp_data: assert property (@(posedge __clk) disable iff (!rst_n)
		rsp_valid |-> (rsp_data == head_data))
		else fail_stop($sformatf("[FAIL] %s rsp_data: expected %h actual %h",
			test_name, $sampled(head_data), $sampled(rsp_data)));

	a_outstanding_max: assert property (@(posedge __clk) disable iff (!rst_n)
		acc_cnt <= rsp_cnt + cpu_pkg::FIFO_DEPTH + 1)
		else fail_stop("More commands accepted than the queue and bus master can hold");

	// Full path must refuse further commands
	a_ready_low_full: assert property (@(posedge __clk) disable iff (!rst_n)
		(acc_cnt - rsp_cnt >= cpu_pkg::FIFO_DEPTH + 1) |-> !cmd_ready)
		else fail_stop("cmd_ready stayed high with the request path full");

	a_awaria_quiet: assert property (@(posedge __clk) disable iff (!rst_n)
		!alarm_issued |-> !awaria)
		else fail_stop("awaria rose before any request to a silent page");

	a_awaria_sticky: assert property (@(posedge __clk) disable iff (!rst_n)
		awaria |=> awaria)
		else fail_stop("awaria fell without a reset");

	a_alarm_flag: assert property (@(posedge __clk) disable iff (!rst_n)
		(rsp_valid && rsp_status == cpu_pkg::ST_ALARM) |-> awaria)
		else fail_stop("Alarm response given while awaria was low");

	a_no_dw: assert property (@(posedge __clk) disable iff (!rst_n)
		no_dw_watch |-> !dw)
		else fail_stop("dw was raised for a refused page 0 write");

	a_no_din: assert property (@(posedge __clk) disable iff (!rst_n)
		no_din_watch |-> !din)
		else fail_stop("din was raised for an unfitted I/O channel");

	// -----------------------------------------------------------------
	// Stimulus helpers
	// -----------------------------------------------------------------

	// Expected response from the bus rules, in command order
	task automatic note_expected(input logic io, input logic write,
		input cpu_pkg::bus_addr_u addr, input logic [0:cpu_pkg::WORD_W-1] data);
		logic [0:cpu_pkg::STATUS_W-1] st;
		logic [0:cpu_pkg::WORD_W-1]   rd;
		st = cpu_pkg::ST_OK;
		rd = '0;
		if (!io && write && cpu_pkg::LOW_MEM_WRITE_DENY && addr.mem.page == 4'd0)
			st = cpu_pkg::ST_DENIED;
		else if (io && !cpu_pkg::IO_CHAN_MASK[addr.io.chan])
			st = cpu_pkg::ST_NODEV;
		else if (io && addr.io.dev == 4'hf)
			st = cpu_pkg::ST_EN;
		else if (io)
			rd = write ? '0 : (addr ^ 16'h5a5a);
		else if (addr.mem.page == 4'hf)
			st = cpu_pkg::ST_ALARM;
		else if (write && addr.mem.offset == 12'hfff)
			st = cpu_pkg::ST_PE;
		else if (write)
			shadow[addr] = data;
		else
			rd = shadow.exists(addr) ? shadow[addr] : '0;
		exp_status[issue_cnt] = st;
		exp_data[issue_cnt] = rd;
		issue_cnt++;
	endtask

	// Called on a falling edge, returns on the falling edge after accept
	task automatic send_cmd(input logic io, input logic write,
		input cpu_pkg::bus_addr_u addr, input logic [0:cpu_pkg::WORD_W-1] data);
		int waited;
		waited = 0;
		while (!cmd_ready) begin
			if (waited == WAIT_LIMIT)
				fail_stop($sformatf("%s: cmd_ready stayed low too long", test_name));
			else begin
				waited++;
				@(negedge __clk);
			end
		end
		note_expected(io, write, addr, data);
		cmd_valid = 1'b1;
		cmd_io = io;
		cmd_write = write;
		cmd_addr = addr;
		cmd_data = data;
		@(negedge __clk);
		cmd_valid = 1'b0;
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (rsp_cnt != issue_cnt) begin
			if (waited == WAIT_LIMIT)
				fail_stop($sformatf("%s: only %0d of %0d responses arrived",
					test_name, rsp_cnt, issue_cnt));
			else begin
				waited++;
				@(negedge __clk);
			end
		end
	endtask

	// -----------------------------------------------------------------
	// Test sequence
	// -----------------------------------------------------------------

	initial begin
		logic [0:cpu_pkg::WORD_W-1] addrs [6];
		int i;
		void'($urandom(38));
		rst_n = 1'b0;
		cmd_valid = 1'b0;
		cmd_io = 1'b0;
		cmd_write = 1'b0;
		cmd_addr = '0;
		cmd_data = '0;
		slow = 1'b0;
		issue_cnt = 0;
		alarm_issued = 1'b0;
		no_dw_watch = 1'b0;
		no_din_watch = 1'b0;
		test_name = "reset";
		repeat (3) @(negedge __clk);
		rst_n = 1'b1;
		@(negedge __clk);

		test_name = "mem_write_read";
		for (i = 0; i < 6; i++)
			addrs[i] = {4'($urandom_range(1, 14)), 12'($urandom_range(0, 12'hffe))};
		for (i = 0; i < 12; i++)
			send_cmd(1'b0, 1'b1, addrs[i % 6], 16'($urandom));
		for (i = 0; i < 6; i++)
			send_cmd(1'b0, 1'b0, addrs[i], '0);
		drain();

		test_name = "page0_deny";
		no_dw_watch = 1'b1;
		send_cmd(1'b0, 1'b1, {4'd0, 12'h123}, 16'hbeef);
		drain();
		no_dw_watch = 1'b0;

		test_name = "io_and_parity";
		no_din_watch = 1'b1;
		send_cmd(1'b1, 1'b0, {4'd9, 4'd1, 8'h20}, '0);
		send_cmd(1'b1, 1'b1, {4'd9, 4'd2, 8'h21}, 16'h1111);
		drain();
		no_din_watch = 1'b0;
		send_cmd(1'b1, 1'b0, {4'd2, 4'd3, 8'h44}, '0);
		send_cmd(1'b1, 1'b1, {4'd2, 4'd3, 8'h45}, 16'h7e7e);
		send_cmd(1'b1, 1'b0, {4'd2, 4'd15, 8'h46}, '0);
		send_cmd(1'b0, 1'b1, {4'd5, 12'hfff}, 16'h0f0f);
		drain();

		test_name = "alarm";
		alarm_issued = 1'b1;
		send_cmd(1'b0, 1'b0, {4'd15, 12'h010}, '0);
		send_cmd(1'b0, 1'b1, {4'd3, 12'h200}, 16'hcafe);
		send_cmd(1'b0, 1'b0, {4'd3, 12'h200}, '0);
		drain();

		test_name = "back_pressure";
		slow = 1'b1;
		for (i = 0; i < 5; i++)
			send_cmd(1'b0, 1'b1, {4'd7, 12'(i + 16)}, 16'($urandom));
		for (i = 0; i < 5; i++)
			send_cmd(1'b0, 1'b0, {4'd7, 12'(i + 16)}, '0);
		drain();
		slow = 1'b0;
		assert (saw_stall)
			else fail_stop("cmd_ready never fell while the bus was slowed");

		if (rsp_cnt != issue_cnt || acc_cnt != issue_cnt)
			fail_stop("Accepted, issued and answered command counts differ");
		else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: tb_bus_slave.sv
// Behavioural system bus responder
// Memory on pages 0 to 14 with a random reply delay, page 15 silent,
// I/O replies built from the address word

`timescale 1ns/1ps
`default_nettype none

module tb_bus_slave (
	input  logic                       __clk,
	input  logic                       rst_n,
	input  logic                       slow,
	input  logic                       dr,
	input  logic                       dw,
	input  logic                       din,
	input  logic [0:cpu_pkg::WORD_W-1] dad,
	input  logic [0:cpu_pkg::WORD_W-1] ddt,
	output logic                       rok,
	output logic                       ren,
	output logic                       rpe,
	output logic [0:cpu_pkg::WORD_W-1] rdt
);

	// Extra reply delay, well below the alarm delay
	localparam int SLOW_EXTRA = 30;

	logic [0:cpu_pkg::WORD_W-1] mem [65536];
	cpu_pkg::bus_addr_u         addr;
	logic                       busy;
	int                         delay;
	int                         waited;

	assign addr = dad;

	initial begin
		int a;
		for (a = 0; a < 65536; a++)
			mem[a] = 16'(a) ^ 16'h3c96;
	end

	// Replies change on the falling edge and hold until the strobes fall
	always @(negedge __clk) begin
		if (!rst_n || !(dr || dw)) begin
			rok <= 1'b0;
			ren <= 1'b0;
			rpe <= 1'b0;
			rdt <= '0;
			busy <= 1'b0;
			waited <= 0;
		end else if (!busy) begin
			busy <= 1'b1;
			waited <= 1;
			delay <= $urandom_range(1, 6) + (slow ? SLOW_EXTRA : 0);
		end else if (waited < delay) begin
			waited <= waited + 1;
		end else if (!(rok || ren || rpe)) begin
			if (din) begin
				if (addr.io.dev == 4'hf) begin
					ren <= 1'b1;
				end else begin
					rok <= 1'b1;
					rdt <= dr ? (dad ^ 16'h5a5a) : '0;
				end
			end else if (addr.mem.page != 4'hf) begin
				if (dw && addr.mem.offset == 12'hfff) begin
					rpe <= 1'b1;
				end else if (dw) begin
					mem[dad] <= ddt;
					rok <= 1'b1;
				end else begin
					rok <= 1'b1;
					rdt <= mem[dad];
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: bus_cpu.sv
// CPU system bus request path
// Issuer, request queue and bus master between the command port and
// the system bus

`timescale 1ns/1ps
`default_nettype none

module bus_cpu (
	input  logic                         __clk,
	input  logic                         rst_n,

	// Command port
	input  logic                         cmd_valid,
	output logic                         cmd_ready,
	input  logic                         cmd_io,
	input  logic                         cmd_write,
	input  cpu_pkg::bus_addr_u           cmd_addr,
	input  logic [0:cpu_pkg::WORD_W-1]   cmd_data,

	// System bus
	output logic                         dr,
	output logic                         dw,
	output logic                         din,
	output logic [0:cpu_pkg::WORD_W-1]   dad,
	output logic [0:cpu_pkg::WORD_W-1]   ddt,
	input  logic                         rok,
	input  logic                         ren,
	input  logic                         rpe,
	input  logic [0:cpu_pkg::WORD_W-1]   rdt,

	// Response and alarm
	output logic                         rsp_valid,
	output logic [0:cpu_pkg::STATUS_W-1] rsp_status,
	output logic [0:cpu_pkg::WORD_W-1]   rsp_data,
	output logic                         awaria
);

	// ---------------------------------------------------------------------
	// Issuer to queue
	// ---------------------------------------------------------------------

	logic                       push;
	logic                       push_io;
	logic                       push_write;
	cpu_pkg::bus_addr_u         push_addr;
	logic [0:cpu_pkg::WORD_W-1] push_data;
	logic                       credit_return;

	bus_req_issue i_bus_req_issue (
		.__clk(__clk),
		.rst_n(rst_n),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.cmd_io(cmd_io),
		.cmd_write(cmd_write),
		.cmd_addr(cmd_addr),
		.cmd_data(cmd_data),
		.push(push),
		.push_io(push_io),
		.push_write(push_write),
		.push_addr(push_addr),
		.push_data(push_data),
		.credit_return(credit_return)
	);

	// ---------------------------------------------------------------------
	// Queue to bus master
	// ---------------------------------------------------------------------

	logic                       head_valid;
	logic                       head_io;
	logic                       head_write;
	cpu_pkg::bus_addr_u         head_addr;
	logic [0:cpu_pkg::WORD_W-1] head_data;
	logic                       pop;

	bus_req_fifo i_bus_req_fifo (
		.__clk(__clk),
		.rst_n(rst_n),
		.push(push),
		.push_io(push_io),
		.push_write(push_write),
		.push_addr(push_addr),
		.push_data(push_data),
		.credit_return(credit_return),
		.head_valid(head_valid),
		.head_io(head_io),
		.head_write(head_write),
		.head_addr(head_addr),
		.head_data(head_data),
		.pop(pop)
	);

	bus_master i_bus_master (
		.__clk(__clk),
		.rst_n(rst_n),
		.head_valid(head_valid),
		.head_io(head_io),
		.head_write(head_write),
		.head_addr(head_addr),
		.head_data(head_data),
		.pop(pop),
		.dr(dr),
		.dw(dw),
		.din(din),
		.dad(dad),
		.ddt(ddt),
		.rok(rok),
		.ren(ren),
		.rpe(rpe),
		.rdt(rdt),
		.rsp_valid(rsp_valid),
		.rsp_status(rsp_status),
		.rsp_data(rsp_data),
		.awaria(awaria)
	);

endmodule

`default_nettype wire

// File: bus_master.sv
// System bus master
// Pulls one request at a time, refuses protected writes and unfitted
// I/O channels locally, otherwise runs a bus cycle and waits for the
// reply, raising the alarm when none comes in time

`timescale 1ns/1ps
`default_nettype none

module bus_master (
	input  logic                         __clk,
	input  logic                         rst_n,

	// From request queue
	input  logic                         head_valid,
	input  logic                         head_io,
	input  logic                         head_write,
	input  cpu_pkg::bus_addr_u           head_addr,
	input  logic [0:cpu_pkg::WORD_W-1]   head_data,
	output logic                         pop,

	// System bus
	output logic                         dr,
	output logic                         dw,
	output logic                         din,
	output logic [0:cpu_pkg::WORD_W-1]   dad,
	output logic [0:cpu_pkg::WORD_W-1]   ddt,
	input  logic                         rok,
	input  logic                         ren,
	input  logic                         rpe,
	input  logic [0:cpu_pkg::WORD_W-1]   rdt,

	// Response
	output logic                         rsp_valid,
	output logic [0:cpu_pkg::STATUS_W-1] rsp_status,
	output logic [0:cpu_pkg::WORD_W-1]   rsp_data,
	output logic                         awaria
);

	logic [cpu_pkg::BM_STATE_W-1:0]  state;
	logic [cpu_pkg::BM_STATE_W-1:0]  state_nxt;
	logic                            req_io;
	logic                            req_write;
	cpu_pkg::bus_addr_u              req_addr;
	logic [0:cpu_pkg::WORD_W-1]      req_data;
	logic [cpu_pkg::ALARM_CNT_W-1:0] alarm_cnt;
	logic [0:cpu_pkg::STATUS_W-1]    fin_status;
	logic [0:cpu_pkg::WORD_W-1]      fin_data;
	logic [0:cpu_pkg::STATUS_W-1]    chk_status;
	logic                            deny_write;
	logic                            no_dev;
	logic                            refused;
	logic                            strobe_on;
	logic                            reply;
	logic                            timeout;

	// ---------------------------------------------------------------------
	// Local access rules
	// ---------------------------------------------------------------------

	assign deny_write = cpu_pkg::LOW_MEM_WRITE_DENY && !req_io && req_write
		&& (req_addr.mem.page == 4'd0);
	assign no_dev = req_io && !cpu_pkg::IO_CHAN_MASK[req_addr.io.chan];
	assign refused = deny_write || no_dev;
	assign chk_status = no_dev ? cpu_pkg::ST_NODEV : cpu_pkg::ST_DENIED;

	// Strobes go up as soon as the check passes
	assign strobe_on = (state == cpu_pkg::BM_STROBE)
		|| ((state == cpu_pkg::BM_CHECK) && !refused);
	assign reply = rok || ren || rpe;
	assign timeout = (alarm_cnt == cpu_pkg::ALARM_DLY_TICKS - 1);

	assign pop = (state == cpu_pkg::BM_IDLE) && head_valid;

	// ---------------------------------------------------------------------
	// FSM
	// ---------------------------------------------------------------------

	always_comb begin
		state_nxt = state;
		case (state)
			cpu_pkg::BM_IDLE: begin
				if (head_valid)
					state_nxt = cpu_pkg::BM_CHECK;
			end
			cpu_pkg::BM_CHECK: begin
				if (refused)
					state_nxt = cpu_pkg::BM_IDLE;
				else if (reply || timeout)
					state_nxt = cpu_pkg::BM_FINISH;
				else
					state_nxt = cpu_pkg::BM_STROBE;
			end
			cpu_pkg::BM_STROBE: begin
				if (reply || timeout)
					state_nxt = cpu_pkg::BM_FINISH;
			end
			default: state_nxt = cpu_pkg::BM_IDLE;
		endcase
	end

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= cpu_pkg::BM_IDLE;
			alarm_cnt <= '0;
			awaria <= 1'b0;
		end else begin
			state <= state_nxt;
			if (pop)
				alarm_cnt <= '0;
			else if (strobe_on)
				alarm_cnt <= alarm_cnt + 1'b1;
			// Sticky until reset
			if (strobe_on && !reply && timeout)
				awaria <= 1'b1;
		end
	end

	// Request capture and reply sampling
	always_ff @(posedge __clk) begin
		if (pop) begin
			req_io <= head_io;
			req_write <= head_write;
			req_addr <= head_addr;
			req_data <= head_data;
		end
		if (strobe_on) begin
			if (rok) begin
				fin_status <= cpu_pkg::ST_OK;
				fin_data <= req_write ? '0 : rdt;
			end else if (ren) begin
				fin_status <= cpu_pkg::ST_EN;
				fin_data <= '0;
			end else if (rpe) begin
				fin_status <= cpu_pkg::ST_PE;
				fin_data <= '0;
			end else begin
				fin_status <= cpu_pkg::ST_ALARM;
				fin_data <= '0;
			end
		end
	end

	// ---------------------------------------------------------------------
	// Bus and response outputs
	// ---------------------------------------------------------------------

	assign dr = strobe_on && !req_write;
	assign dw = strobe_on && req_write;
	assign din = strobe_on && req_io;
	assign dad = strobe_on ? req_addr : '0;
	assign ddt = dw ? req_data : '0;

	assign rsp_valid = (state == cpu_pkg::BM_FINISH)
		|| ((state == cpu_pkg::BM_CHECK) && refused);
	assign rsp_status = (state == cpu_pkg::BM_CHECK) ? chk_status : fin_status;
	assign rsp_data = (state == cpu_pkg::BM_FINISH) ? fin_data : '0;

	a_dr_dw_excl: assert property (
		@(posedge __clk) disable iff (!rst_n)
		!(dr && dw)
	);

	// I/O qualifier never appears on its own
	a_din_with_strobe: assert property (
		@(posedge __clk) disable iff (!rst_n)
		$rose(din) |-> (dr || dw)
	);

	// Address and data hold for the whole bus cycle
	a_bus_stable: assert property (
		@(posedge __clk) disable iff (!rst_n)
		(dr || dw) ##1 (dr || dw) |-> ($stable(dad) && $stable(ddt))
	);

endmodule

`default_nettype wire

// File: bus_req_fifo.sv
// Bus request queue
// Circular buffer of pending bus requests, head offered to the bus
// master, one credit sent back to the issuer for each entry taken

`timescale 1ns/1ps
`default_nettype none

module bus_req_fifo (
	input  logic                       __clk,
	input  logic                       rst_n,

	// From issuer
	input  logic                       push,
	input  logic                       push_io,
	input  logic                       push_write,
	input  cpu_pkg::bus_addr_u         push_addr,
	input  logic [0:cpu_pkg::WORD_W-1] push_data,
	output logic                       credit_return,

	// To bus master
	output logic                       head_valid,
	output logic                       head_io,
	output logic                       head_write,
	output cpu_pkg::bus_addr_u         head_addr,
	output logic [0:cpu_pkg::WORD_W-1] head_data,
	input  logic                       pop
);

	logic                           ent_io    [cpu_pkg::FIFO_DEPTH];
	logic                           ent_write [cpu_pkg::FIFO_DEPTH];
	cpu_pkg::bus_addr_u             ent_addr  [cpu_pkg::FIFO_DEPTH];
	logic [0:cpu_pkg::WORD_W-1]     ent_data  [cpu_pkg::FIFO_DEPTH];
	logic [cpu_pkg::FIFO_PTR_W-1:0] wr_ptr;
	logic [cpu_pkg::FIFO_PTR_W-1:0] rd_ptr;
	logic [cpu_pkg::FIFO_CNT_W-1:0] fill;
	logic                           take;

	assign head_valid = (fill != '0);
	assign take = pop && head_valid;
	assign credit_return = take;

	// Head entry
	assign head_io = ent_io[rd_ptr];
	assign head_write = ent_write[rd_ptr];
	assign head_addr = ent_addr[rd_ptr];
	assign head_data = ent_data[rd_ptr];

	// Entry storage
	always_ff @(posedge __clk) begin
		if (push) begin
			ent_io[wr_ptr] <= push_io;
			ent_write[wr_ptr] <= push_write;
			ent_addr[wr_ptr] <= push_addr;
			ent_data[wr_ptr] <= push_data;
		end
	end

	// Pointers and fill level
	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == cpu_pkg::FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (take)
				rd_ptr <= (rd_ptr == cpu_pkg::FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			case ({push, take})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	// Credit flow keeps the issuer from overrunning the buffer
	a_no_push_full: assert property (
		@(posedge __clk) disable iff (!rst_n)
		push |-> (fill != cpu_pkg::FIFO_DEPTH)
	);

	// Bus master only pulls an offered head
	a_no_pop_empty: assert property (
		@(posedge __clk) disable iff (!rst_n)
		pop |-> head_valid
	);

endmodule

`default_nettype wire

// File: bus_req_issue.sv
// Bus request issuer
// Takes transfer commands from the sequencer side and pushes them into
// the request queue while credits remain

`timescale 1ns/1ps
`default_nettype none

module bus_req_issue (
	input  logic                       __clk,
	input  logic                       rst_n,

	// Command port
	input  logic                       cmd_valid,
	output logic                       cmd_ready,
	input  logic                       cmd_io,
	input  logic                       cmd_write,
	input  cpu_pkg::bus_addr_u         cmd_addr,
	input  logic [0:cpu_pkg::WORD_W-1] cmd_data,

	// Queue push side
	output logic                       push,
	output logic                       push_io,
	output logic                       push_write,
	output cpu_pkg::bus_addr_u         push_addr,
	output logic [0:cpu_pkg::WORD_W-1] push_data,
	input  logic                       credit_return
);

	logic [cpu_pkg::CREDIT_W-1:0] credits;

	// ---------------------------------------------------------------------
	// Handshake
	// ---------------------------------------------------------------------

	// Ready as long as one queue slot is known free
	assign cmd_ready = (credits != '0);
	assign push = cmd_valid && cmd_ready;

	// Fields go straight to the queue in the accept cycle
	assign push_io = cmd_io;
	assign push_write = cmd_write;
	assign push_addr = cmd_addr;
	assign push_data = cmd_data;

	// ---------------------------------------------------------------------
	// Credit counter
	// ---------------------------------------------------------------------

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			credits <= cpu_pkg::FIFO_DEPTH[cpu_pkg::CREDIT_W-1:0];
		end else begin
			case ({push, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				// Push and return together cancel out
				default: credits <= credits;
			endcase
		end
	end

	// Queue only hands back credits for entries it was given
	a_credit_max: assert property (
		@(posedge __clk) disable iff (!rst_n)
		credits <= cpu_pkg::FIFO_DEPTH
	);

endmodule

`default_nettype wire

// File: cpu_pkg.sv
// CPU system bus request path definitions
// Word and queue sizing, bus timing, reply status codes, bus master
// state encoding and the two decodings of a bus address word

`default_nettype none

package cpu_pkg;

	// ---------------------------------------------------------------------
	// Word and queue sizing
	// ---------------------------------------------------------------------

	localparam int WORD_W = 16;
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
	// Counts 0 up to FIFO_DEPTH
	localparam int CREDIT_W = 3;

	// ---------------------------------------------------------------------
	// Bus timing and local access rules
	// ---------------------------------------------------------------------

	// Cycles from strobe assertion until the alarm fires
	localparam int ALARM_DLY_TICKS = 250;
	localparam int ALARM_CNT_W = 8;

	// Page 0 write protection
	localparam logic LOW_MEM_WRITE_DENY = 1'b1;
	// Bit 0 is channel 0, channels 0..7 fitted
	localparam logic [0:15] IO_CHAN_MASK = 16'hff00;

	// Reply status codes
	localparam int STATUS_W = 3;
	localparam logic [0:STATUS_W-1] ST_OK     = 3'd0;
	localparam logic [0:STATUS_W-1] ST_EN     = 3'd1;
	localparam logic [0:STATUS_W-1] ST_PE     = 3'd2;
	localparam logic [0:STATUS_W-1] ST_ALARM  = 3'd3;
	localparam logic [0:STATUS_W-1] ST_DENIED = 3'd4;
	localparam logic [0:STATUS_W-1] ST_NODEV  = 3'd5;

	// Bus master states
	localparam int BM_STATE_W = 2;
	localparam logic [BM_STATE_W-1:0] BM_IDLE   = 2'd0;
	localparam logic [BM_STATE_W-1:0] BM_CHECK  = 2'd1;
	localparam logic [BM_STATE_W-1:0] BM_STROBE = 2'd2;
	localparam logic [BM_STATE_W-1:0] BM_FINISH = 2'd3;

	// One address word seen as memory or as I/O
	typedef union packed {
		struct packed {
			logic [0:3]  page;
			logic [0:11] offset;
		} mem;
		struct packed {
			logic [0:3] chan;
			logic [0:3] dev;
			logic [0:7] cmd;
		} io;
	} bus_addr_u;

endpackage

`default_nettype wire
